// File: rtl/chan_regs.sv
module chan_regs
	import trig_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        frame_done,
	input  logic        frame_ok,
	input  frame_t      frame,
	output chan_bytes_t trig_level,
	output chan_bytes_t vector,
	output logic        armed
);

	chan_idx_t chan;
	cmd_e      cmd;
	logic      wr_en;

	// channel range already checked by the decoder
	assign chan  = chan_idx_t'(frame[1]);
	assign cmd   = cmd_e'(frame[0]);
	assign wr_en = frame_done && frame_ok;

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			trig_level <= '0;
			vector     <= '0;
			armed      <= 1'b0;
		end else if (wr_en) begin
			case (cmd)
				CMD_TRIG_SET: begin
					// level in byte 3, arms the trigger
					trig_level[chan] <= frame[3];
					armed            <= 1'b1;
				end
				CMD_TRIG_CLR: begin
					armed <= 1'b0;
				end
				CMD_VECTOR: begin
					vector[chan] <= frame[2];
				end
				default: begin
					// nop writes nothing
				end
			endcase
		end
	end

endmodule

// File: rtl/frame_decoder.sv
module frame_decoder
	import trig_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  baud_sel_t baud,
	input  logic      byte_valid,
	input  byte_t     byte_data,
	input  logic      reply_busy,
	output logic      frame_done,
	output logic      frame_ok,
	output frame_t    frame
);

	logic [DIV_W-1:0] div;
	logic [DIV_W-1:0] gap_cnt;
	logic [4:0]       gap_bits;
	logic [1:0]       byte_cnt;
	frame_t           frm;
	frame_t           frm_next;
	cmd_e             cmd;
	logic             chan_ok;
	logic             rules_ok;

	assign div = bit_div(baud);

	// newest byte enters at the top, command ends up in index 0
	assign frm_next = {byte_data, frm[FRAME_BYTES-1:1]};
	assign frame    = frm;

	assign cmd     = cmd_e'(frm_next[0]);
	assign chan_ok = (frm_next[1] < 8'(NUM_CHAN));

	// command rules, checked against the frame as it completes
	always_comb begin
		case (cmd)
			CMD_NOP:      rules_ok = chan_ok;
			CMD_TRIG_CLR: rules_ok = chan_ok;
			CMD_VECTOR:   rules_ok = chan_ok;
			CMD_TRIG_SET: begin
				// trigger type 1 or 2 only
				rules_ok = chan_ok && (frm_next[2] == 8'd1 || frm_next[2] == 8'd2);
			end
			default:      rules_ok = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (byte_valid)
			frm <= frm_next;
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			byte_cnt   <= '0;
			gap_cnt    <= '0;
			gap_bits   <= '0;
			frame_done <= 1'b0;
			frame_ok   <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (byte_valid) begin
				gap_cnt  <= '0;
				gap_bits <= '0;
				if (byte_cnt == 2'(FRAME_BYTES - 1)) begin
					byte_cnt <= '0;
					// reply still going out, frame is dropped
					frame_done <= !reply_busy;
					frame_ok   <= rules_ok;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end else if (byte_cnt != '0) begin
				// partial frame, watch for a quiet line
				if (gap_cnt == div - 1'b1) begin
					gap_cnt <= '0;
					if (gap_bits == 5'(GAP_BITS - 1)) begin
						gap_bits <= '0;
						byte_cnt <= '0;
					end else begin
						gap_bits <= gap_bits + 1'b1;
					end
				end else begin
					gap_cnt <= gap_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/reply_tx.sv
module reply_tx
	import trig_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  baud_sel_t baud,
	input  logic      frame_done,
	input  logic      frame_ok,
	input  frame_t    frame,
	output logic      tx,
	output logic      reply_busy
);

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_e;

	tx_state_e        state;
	logic [DIV_W-1:0] div;
	logic [DIV_W-1:0] cnt;
	logic             bit_end;
	logic             load;
	frame_t           reply_val;
	frame_t           rep;
	logic [8:0]       sh;
	logic [3:0]       bits_left;
	logic [1:0]       byte_idx;

	assign div     = bit_div(baud);
	assign bit_end = (cnt == div - 1'b1);
	assign load    = (state == TX_IDLE) && frame_done;

	// echo on a good frame, all error bytes otherwise
	assign reply_val = frame_ok ? frame : {FRAME_BYTES{ERR_BYTE}};

	assign reply_busy = (state == TX_SEND);

	// data bits with the stop bit on top, shifted out lsb first
	always_ff @(posedge clk) begin
		if (load) begin
			rep <= reply_val;
			sh  <= {1'b1, reply_val[0]};
		end else if (state == TX_SEND && bit_end) begin
			if (bits_left != 4'd0)
				sh <= {1'b1, sh[8:1]};
			else
				sh <= {1'b1, rep[byte_idx + 1'b1]};
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state     <= TX_IDLE;
			tx        <= 1'b1;
			cnt       <= '0;
			bits_left <= '0;
			byte_idx  <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (frame_done) begin
						// start bit of the first byte
						state     <= TX_SEND;
						tx        <= 1'b0;
						cnt       <= '0;
						bits_left <= 4'd9;
						byte_idx  <= '0;
					end
				end
				TX_SEND: begin
					if (bit_end) begin
						cnt <= '0;
						if (bits_left != 4'd0) begin
							tx        <= sh[0];
							bits_left <= bits_left - 1'b1;
						end else if (byte_idx == 2'(FRAME_BYTES - 1)) begin
							// last stop bit done, line stays high
							state <= TX_IDLE;
						end else begin
							// next byte follows with no idle bits
							byte_idx  <= byte_idx + 1'b1;
							tx        <= 1'b0;
							bits_left <= 4'd9;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/trig_ctrl_pkg.sv
package trig_ctrl_pkg;

	// bit timer width and frame geometry
	localparam int DIV_W       = 20;
	localparam int FRAME_BYTES = 4;
	localparam int NUM_CHAN    = 4;

	// quiet bit times before a partial frame is abandoned
	localparam int GAP_BITS = 20;

	// clocks per bit for baud codes 0 to 3
	localparam logic [DIV_W-1:0] BIT_DIV_110  = 20'd109091;
	localparam logic [DIV_W-1:0] BIT_DIV_600  = 20'd20000;
	localparam logic [DIV_W-1:0] BIT_DIV_2400 = 20'd5000;
	localparam logic [DIV_W-1:0] BIT_DIV_9600 = 20'd1250;

	typedef logic [7:0] byte_t;
	typedef logic [1:0] chan_idx_t;
	typedef logic [1:0] baud_sel_t;

	// index 0 is channel 0
	typedef byte_t [NUM_CHAN-1:0] chan_bytes_t;

	// index 0 is the first byte received, the command
	typedef byte_t [FRAME_BYTES-1:0] frame_t;

	// reply byte for a rejected frame
	localparam byte_t ERR_BYTE = 8'hFF;

	typedef enum logic [7:0] {
		CMD_NOP      = 8'h00,
		CMD_TRIG_SET = 8'h53,
		CMD_TRIG_CLR = 8'h5C,
		CMD_VECTOR   = 8'hA5
	} cmd_e;

	function automatic logic [DIV_W-1:0] bit_div(input baud_sel_t sel);
		case (sel)
			2'd0:    return BIT_DIV_110;
			2'd1:    return BIT_DIV_600;
			2'd2:    return BIT_DIV_2400;
			default: return BIT_DIV_9600;
		endcase
	endfunction

endpackage

// File: rtl/trig_ctrl_top.sv
module trig_ctrl_top
	import trig_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  baud_sel_t   baud,
	input  logic        rx,
	output logic        tx,
	output chan_bytes_t trig_level,
	output chan_bytes_t vector,
	output logic        armed
);

	logic   byte_valid;
	byte_t  byte_data;
	logic   frame_done;
	logic   frame_ok;
	frame_t frame;
	logic   reply_busy;

	uart_rx i_uart_rx (
		.clk        (clk),
		.nrst       (nrst),
		.baud       (baud),
		.rx         (rx),
		.byte_valid (byte_valid),
		.byte_data  (byte_data)
	);

	frame_decoder i_frame_decoder (
		.clk        (clk),
		.nrst       (nrst),
		.baud       (baud),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.reply_busy (reply_busy),
		.frame_done (frame_done),
		.frame_ok   (frame_ok),
		.frame      (frame)
	);

	chan_regs i_chan_regs (
		.clk        (clk),
		.nrst       (nrst),
		.frame_done (frame_done),
		.frame_ok   (frame_ok),
		.frame      (frame),
		.trig_level (trig_level),
		.vector     (vector),
		.armed      (armed)
	);

	// reply goes out while the next frame is received
	reply_tx i_reply_tx (
		.clk        (clk),
		.nrst       (nrst),
		.baud       (baud),
		.frame_done (frame_done),
		.frame_ok   (frame_ok),
		.frame      (frame),
		.tx         (tx),
		.reply_busy (reply_busy)
	);

endmodule

// File: rtl/uart_rx.sv
module uart_rx
	import trig_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      nrst,
	input  baud_sel_t baud,
	input  logic      rx,
	output logic      byte_valid,
	output byte_t     byte_data
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e        state;
	logic             rx_meta;
	logic             rx_s;
	logic [DIV_W-1:0] div;
	logic [DIV_W-1:0] cnt;
	logic             half_end;
	logic             bit_end;
	logic [2:0]       bit_idx;
	byte_t            shreg;

	assign div      = bit_div(baud);
	assign half_end = (cnt == (div >> 1) - 1'b1);
	assign bit_end  = (cnt == div - 1'b1);

	assign byte_data = shreg;

	// two flop synchronizer, idles high
	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rx_meta <= 1'b1;
			rx_s    <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_s    <= rx_meta;
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state      <= RX_IDLE;
			cnt        <= '0;
			bit_idx    <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					cnt <= '0;
					if (!rx_s)
						state <= RX_START;
				end
				RX_START: begin
					// half a bit in, line must still be low
					if (half_end) begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_s ? RX_IDLE : RX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				RX_STOP: begin
					// low stop bit means a framing error, byte dropped
					if (bit_end) begin
						cnt        <= '0;
						byte_valid <= rx_s;
						state      <= RX_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end)
			shreg <= {rx_s, shreg[7:1]};
	end

endmodule

// File: run.sh
#!/bin/sh
# build and run the trigger controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_trig_ctrl -f tb.f -o sim_trig_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_trig_ctrl
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0

// File: tb.f
rtl/trig_ctrl_pkg.sv
rtl/uart_rx.sv
rtl/frame_decoder.sv
rtl/chan_regs.sv
rtl/reply_tx.sv
rtl/trig_ctrl_top.sv
verification/tb_trig_ctrl.sv

// File: verification/tb_trig_ctrl.sv
module tb_trig_ctrl
	import trig_ctrl_pkg::*;
();

	localparam int MAX_CASES = 64;
	localparam int FIELDS    = 8;

	logic        clk = 1'b0;
	logic        nrst;
	baud_sel_t   baud;
	logic        rx;
	logic        tx;
	chan_bytes_t trig_level;
	chan_bytes_t vector;
	logic        armed;

	byte_t       case_mem [MAX_CASES*FIELDS];
	int          num_cases;
	longint      cycles = 0;
	longint      cycle_limit = 0;
	logic [31:0] rng;
	byte_t       rx_bytes [FRAME_BYTES];

	// reference model of the register banks
	chan_bytes_t exp_trig;
	chan_bytes_t exp_vec;
	logic        exp_armed;

	trig_ctrl_top i_trig_ctrl_top (
		.clk        (clk),
		.nrst       (nrst),
		.baud       (baud),
		.rx         (rx),
		.tx         (tx),
		.trig_level (trig_level),
		.vector     (vector),
		.armed      (armed)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
			stop_with_fail();
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int clocks_per_bit(input baud_sel_t code);
		case (code)
			2'd0:    return int'(BIT_DIV_110);
			2'd1:    return int'(BIT_DIV_600);
			2'd2:    return int'(BIT_DIV_2400);
			default: return int'(BIT_DIV_9600);
		endcase
	endfunction

	// channel must be 0 to 3 and a set needs trigger type 1 or 2
	function automatic logic frame_valid(input byte_t c, input byte_t ch, input byte_t ty);
		if (ch > 8'd3)
			return 1'b0;
		case (c)
			CMD_NOP, CMD_TRIG_CLR, CMD_VECTOR: return 1'b1;
			CMD_TRIG_SET: return (ty == 8'd1) || (ty == 8'd2);
			default: return 1'b0;
		endcase
	endfunction

	task automatic stop_with_fail();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
			stop_with_fail();
		end
	endtask

	task automatic check_bank(input string name, input chan_bytes_t exp, input chan_bytes_t act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
			stop_with_fail();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
			stop_with_fail();
		end
	endtask

	task automatic check_regs();
		check_bank("trig_level", exp_trig, trig_level);
		check_bank("vector", exp_vec, vector);
		check_flag("armed", exp_armed, armed);
	endtask

	task automatic update_model(input byte_t c, input byte_t ch, input byte_t b2, input byte_t b3);
		case (c)
			CMD_TRIG_SET: begin
				exp_trig[ch[1:0]] = b3;
				exp_armed         = 1'b1;
			end
			CMD_TRIG_CLR: exp_armed = 1'b0;
			CMD_VECTOR:   exp_vec[ch[1:0]] = b2;
			default: begin
				// nop leaves the model as it is
			end
		endcase
	endtask

	// quiet rx line while tx has to stay high
	task automatic idle_bits(input int bits);
		repeat (bits * clocks_per_bit(baud)) begin
			@(negedge clk);
			check_flag("tx", 1'b1, tx);
		end
	endtask

	task automatic send_byte(input byte_t b);
		int    div;
		byte_t sh;
		div = clocks_per_bit(baud);
		sh  = b;
		rx  = 1'b0;
		repeat (div) @(negedge clk);
		repeat (8) begin
			rx = sh[0];
			sh = sh >> 1;
			repeat (div) @(negedge clk);
		end
		rx = 1'b1;
		repeat (div) @(negedge clk);
	endtask

	// decode four bytes from tx at bit centres
	task automatic receive_reply();
		int    div;
		byte_t b;
		div = clocks_per_bit(baud);
		for (int n = 0; n < FRAME_BYTES; n++) begin
			while (tx !== 1'b0)
				@(negedge clk);
			repeat (div / 2) @(negedge clk);
			check_flag("tx start bit", 1'b0, tx);
			repeat (8) begin
				repeat (div) @(negedge clk);
				b = {tx, b[7:1]};
			end
			repeat (div) @(negedge clk);
			check_flag("tx stop bit", 1'b1, tx);
			rx_bytes[n] = b;
		end
	endtask

	task automatic run_case(input int k);
		byte_t f [FRAME_BYTES];
		logic  valid;
		logic  trunc;
		int    base;
		base  = k * FIELDS;
		baud  = baud_sel_t'(case_mem[base]);
		for (int n = 0; n < FRAME_BYTES; n++)
			f[n] = case_mem[base + 1 + n];
		trunc = case_mem[base + 6][0];
		valid = case_mem[base + 7][0];
		if (case_mem[base + 5][0]) begin
			rng = xorshift32(rng);
			idle_bits(1 + int'(rng[2:0]));
		end
		if (trunc) begin
			// partial frame is dropped after the gap without a reply
			send_byte(f[0]);
			send_byte(f[1]);
			idle_bits(GAP_BITS + 4);
			check_regs();
		end else begin
			if (frame_valid(f[0], f[1], f[2]) !== valid) begin
				$display("case %0d: validity in the case file disagrees with the frame rules", k);
				stop_with_fail();
			end
			if (valid)
				update_model(f[0], f[1], f[2], f[3]);
			fork
				begin
					for (int j = 0; j < FRAME_BYTES; j++)
						send_byte(f[j]);
				end
				receive_reply();
			join
			for (int n = 0; n < FRAME_BYTES; n++)
				check_byte($sformatf("tx byte %0d", n), valid ? f[n] : 8'hFF, rx_bytes[n]);
			check_regs();
			// let the last stop bit finish before any baud change
			idle_bits(1);
		end
	endtask

	initial begin
		longint limit;
		nrst      = 1'b0;
		rx        = 1'b1;
		baud      = 2'd3;
		rng       = 32'd49818;
		exp_trig  = '0;
		exp_vec   = '0;
		exp_armed = 1'b0;
		for (int a = 0; a < MAX_CASES * FIELDS; a++)
			case_mem[a] = 8'h80 | byte_t'(a ^ (a >> 5));
		$readmemh("verification/trig_cases.txt", case_mem);
		// baud codes above 3 mark the end of the cases
		num_cases = 0;
		while (num_cases < MAX_CASES && case_mem[num_cases * FIELDS] <= 8'd3)
			num_cases++;
		if (num_cases == 0) begin
			$display("no cases could be read from the case file");
			stop_with_fail();
		end
		limit = 1000;
		for (int k = 0; k < num_cases; k++)
			limit += 100 * longint'(clocks_per_bit(baud_sel_t'(case_mem[k * FIELDS])));
		cycle_limit = limit;
		baud = baud_sel_t'(case_mem[0]);
		repeat (5) @(negedge clk);
		nrst = 1'b1;
		idle_bits(2);
		check_regs();
		for (int k = 0; k < num_cases; k++)
			run_case(k);
		idle_bits(GAP_BITS);
		check_regs();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: verification/trig_cases.txt
// baud b0 b1 b2 b3 gap trunc valid, all hex, one frame per line
// b0 is the command and b1 the channel, trunc sends b0 and b1 only
3 53 00 01 11 0 0 1
3 53 01 02 22 1 0 1
3 53 02 01 33 0 0 1
3 53 03 02 44 1 0 1
3 7E 00 01 55 0 0 0
3 53 04 01 66 1 0 0
3 A5 FF 10 00 0 0 0
3 53 01 00 77 0 0 0
3 53 02 03 88 1 0 0
3 5C 04 00 00 0 0 0
3 5C 00 77 88 1 0 1
3 A5 00 5A 99 0 0 1
3 A5 03 C3 00 1 0 1
3 00 02 12 34 0 0 1
3 53 01 01 AB 1 1 0
3 A5 01 E7 00 0 0 1
2 53 02 02 5D 1 0 1
2 A5 02 3C 00 0 0 1
2 5C 03 00 00 1 1 0
2 5C 01 00 00 0 0 1
2 53 00 03 00 1 0 0
1 53 03 01 E1 1 0 1
3 A5 02 81 FF 1 0 1
3 5C 02 00 00 0 0 1
